// ==== layer_compositor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ovl_macros.svh"

module layer_compositor (
   input  logic            clk,
   input  logic            resetb,
   layer_result_if.snk     layers [`OVL_NUM_LAYERS],
   output logic            dvo,
   output ovl_pkg::dtype_e dtypeo,
   output logic [7:0]      data0o,
   output logic [7:0]      data1o,
   output logic [7:0]      data2o,
   output logic [15:0]     meta_datao
);
   import ovl_pkg::*;

   layer_result_t res [`OVL_NUM_LAYERS];
   logic [7:0]    y_mix;
   logic [7:0]    u_mix;
   logic [7:0]    v_mix;

   // pull the results out of the interface array
   for (genvar g = 0; g < `OVL_NUM_LAYERS; g++) begin : g_res
      assign res[g] = layers[g].res;
   end

   // layer 0 goes down first, each later layer lands on top
   always_comb begin
      y_mix = layers[0].data0;
      u_mix = layers[0].data1;
      v_mix = layers[0].data2;
      for (int i = 0; i < `OVL_NUM_LAYERS; i++) begin
         if (res[i].sel) begin
            y_mix = blend(y_mix, res[i].y, res[i].alpha);
            u_mix = blend(u_mix, res[i].u, res[i].alpha);
            v_mix = blend(v_mix, res[i].v, res[i].alpha);
         end
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         dvo <= 1'b0;
      end else begin
         dvo <= layers[0].dv;
      end
   end

   // every layer carries the same beat, take it from layer 0
   always_ff @(posedge clk) begin
      dtypeo     <= layers[0].dtype;
      data0o     <= y_mix;
      data1o     <= u_mix;
      data2o     <= v_mix;
      meta_datao <= layers[0].meta_data;
   end

endmodule

`default_nettype wire

// ==== overlay_layer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ovl_macros.svh"

module overlay_layer #(
   parameter int LAYER_ID = 0
) (
   input  logic                               clk,
   input  logic                               resetb,
   input  logic                               enable,
   input  logic                               cfg_we,
   input  logic [$clog2(`OVL_NUM_LAYERS)-1:0] cfg_layer,
   input  logic [6:0]                         cfg_addr,
   input  logic [31:0]                        cfg_wdata,
   pix_stream_if.snk                          stream,
   layer_result_if.src                        result
);
   import ovl_pkg::*;

   localparam int LW = $clog2(`OVL_NUM_LAYERS);
   localparam int AW = $clog2(`OVL_MEM_DEPTH);
   localparam int W  = `OVL_DIM_WIDTH;
   localparam logic [LW-1:0] LAYER_SEL = LAYER_ID[LW-1:0];

   logic [W-1:0]  col_start;
   logic [W-1:0]  row_start;
   logic [W-1:0]  num_rows;
   logic [W-1:0]  num_cols;
   logic [31:0]   mem [`OVL_MEM_DEPTH];
   logic [AW-1:0] rd_addr;
   logic          half_ptr;
   logic          cfg_hit;
   logic [W-1:0]  row_end;
   logic [W-1:0]  col_end;
   logic          in_win;
   overlay_word_u word;
   logic [15:0]   half;
   logic [2:0]    alpha;
   logic [6:0]    luma;
   logic          sel;

   assign cfg_hit = cfg_we && (cfg_layer == LAYER_SEL);

   // window registers at addresses 0 to 3
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         col_start <= '0;
         row_start <= '0;
         num_rows  <= '0;
         num_cols  <= '0;
      end else if (cfg_hit) begin
         case (cfg_addr)
            7'd0:    col_start <= cfg_wdata[W-1:0];
            7'd1:    row_start <= cfg_wdata[W-1:0];
            7'd2:    num_rows  <= cfg_wdata[W-1:0];
            7'd3:    num_cols  <= cfg_wdata[W-1:0];
            default: ;
         endcase
      end
   end

   // overlay words from address 64 up
   always_ff @(posedge clk) begin
      if (cfg_hit && cfg_addr[6]) begin
         mem[cfg_addr[AW-1:0]] <= cfg_wdata;
      end
   end

   assign row_end = row_start + num_rows;
   assign col_end = col_start + num_cols;
   assign in_win  = enable && stream.dv && stream.dtype == PIXEL &&
                    stream.row >= row_start && stream.row < row_end &&
                    stream.col >= col_start && stream.col < col_end;

   // low half first, then high half of the same word
   assign word  = mem[rd_addr];
   assign half  = half_ptr ? word.halves.hi : word.halves.lo;
   assign alpha = half_ptr ? word.fields.a_hi : word.fields.a_lo;
   assign luma  = half_ptr ? word.fields.y_hi : word.fields.y_lo;
   // an all-zero half is transparent
   assign sel   = in_win && (half != 16'h0000);

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         rd_addr  <= '0;
         half_ptr <= 1'b0;
      end else if (!enable || (stream.dv && stream.dtype == FRAME_END)) begin
         rd_addr  <= '0;
         half_ptr <= 1'b0;
      end else if (in_win) begin
         half_ptr <= ~half_ptr;
         if (half_ptr) begin
            rd_addr <= rd_addr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         result.dv  <= 1'b0;
         result.res <= '0;
      end else begin
         result.dv        <= stream.dv;
         result.res.sel   <= sel;
         result.res.y     <= {luma, 1'b0};
         result.res.u     <= {word.fields.u, 2'b00};
         result.res.v     <= {word.fields.v, 2'b00};
         result.res.alpha <= alpha;
      end
   end

   // base beat rides along for the compositor
   always_ff @(posedge clk) begin
      result.dtype     <= stream.dtype;
      result.data0     <= stream.data0;
      result.data1     <= stream.data1;
      result.data2     <= stream.data2;
      result.meta_data <= stream.meta_data;
   end

   // a frame must not need more words than the memory holds
   assert property (@(posedge clk) disable iff (!resetb)
      (in_win && half_ptr) |=> (rd_addr != '0))
      else $error("overlay read address ran past the memory depth");

endmodule

`default_nettype wire

// ==== overlay_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ovl_macros.svh"

module overlay_top (
   input  logic                               clk,
   input  logic                               resetb,
   input  logic                               enable,
   input  logic                               dvi,
   input  ovl_pkg::dtype_e                    dtypei,
   input  logic [7:0]                         data0i,
   input  logic [7:0]                         data1i,
   input  logic [7:0]                         data2i,
   input  logic [15:0]                        meta_datai,
   input  logic                               cfg_we,
   input  logic [$clog2(`OVL_NUM_LAYERS)-1:0] cfg_layer,
   input  logic [6:0]                         cfg_addr,
   input  logic [31:0]                        cfg_wdata,
   output logic                               dvo,
   output ovl_pkg::dtype_e                    dtypeo,
   output logic [7:0]                         data0o,
   output logic [7:0]                         data1o,
   output logic [7:0]                         data2o,
   output logic [15:0]                        meta_datao
);

   pix_stream_if   stream ();
   layer_result_if lres [`OVL_NUM_LAYERS] ();

   // stage 1, position tagging
   pixel_position_tracker u_tracker (
      .clk        (clk),
      .resetb     (resetb),
      .enable     (enable),
      .dvi        (dvi),
      .dtypei     (dtypei),
      .data0i     (data0i),
      .data1i     (data1i),
      .data2i     (data2i),
      .meta_datai (meta_datai),
      .stream     (stream.src)
   );

   // stage 2, one overlay per layer
   for (genvar g = 0; g < `OVL_NUM_LAYERS; g++) begin : g_layer
      overlay_layer #(
         .LAYER_ID (g)
      ) u_layer (
         .clk       (clk),
         .resetb    (resetb),
         .enable    (enable),
         .cfg_we    (cfg_we),
         .cfg_layer (cfg_layer),
         .cfg_addr  (cfg_addr),
         .cfg_wdata (cfg_wdata),
         .stream    (stream.snk),
         .result    (lres[g].src)
      );
   end

   // stage 3, blending
   layer_compositor u_compositor (
      .clk        (clk),
      .resetb     (resetb),
      .layers     (lres),
      .dvo        (dvo),
      .dtypeo     (dtypeo),
      .data0o     (data0o),
      .data1o     (data1o),
      .data2o     (data2o),
      .meta_datao (meta_datao)
   );

endmodule

`default_nettype wire

// ==== ovl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ovl_macros.svh"

// registered stream beat with its position attached
interface pix_stream_if;
   import ovl_pkg::*;

   logic                      dv;
   dtype_e                    dtype;
   logic [7:0]                data0;
   logic [7:0]                data1;
   logic [7:0]                data2;
   logic [15:0]               meta_data;
   logic [`OVL_DIM_WIDTH-1:0] row;
   logic [`OVL_DIM_WIDTH-1:0] col;

   modport src (output dv, dtype, data0, data1, data2, meta_data, row, col);
   modport snk (input dv, dtype, data0, data1, data2, meta_data, row, col);
endinterface

// one layer's verdict plus the beat it belongs to
interface layer_result_if;
   import ovl_pkg::*;

   layer_result_t res;
   logic          dv;
   dtype_e        dtype;
   logic [7:0]    data0;
   logic [7:0]    data1;
   logic [7:0]    data2;
   logic [15:0]   meta_data;

   modport src (output res, dv, dtype, data0, data1, data2, meta_data);
   modport snk (input res, dv, dtype, data0, data1, data2, meta_data);
endinterface

`default_nettype wire

// ==== ovl_macros.svh ====
`ifndef OVL_MACROS_SVH
`define OVL_MACROS_SVH

// overlay layers stacked on the base stream
`define OVL_NUM_LAYERS 2

// row and column counters and window registers
`define OVL_DIM_WIDTH 11

// stream token type code
`define OVL_DTYPE_WIDTH 4

// 32-bit words per layer, two overlay pixels in each
`define OVL_MEM_DEPTH 64

`endif

// ==== ovl_pkg.sv ====
`default_nettype none

`include "ovl_macros.svh"

package ovl_pkg;

   // token types carried on the stream
   typedef enum logic [`OVL_DTYPE_WIDTH-1:0] {
      FRAME_START = 4'h1,
      ROW_END     = 4'h2,
      PIXEL       = 4'h3,
      FRAME_END   = 4'h4,
      META        = 4'h5
   } dtype_e;

   // one overlay memory word
   // halves view for the transparency test, fields view for the colour
   typedef union packed {
      struct packed {
         logic [15:0] hi;
         logic [15:0] lo;
      } halves;
      struct packed {
         logic [2:0] a_hi;
         logic [6:0] y_hi;
         logic [5:0] v;
         logic [2:0] a_lo;
         logic [6:0] y_lo;
         logic [5:0] u;
      } fields;
   } overlay_word_u;

   // what one layer contributes to the current beat
   typedef struct packed {
      logic       sel;
      logic [7:0] y;
      logic [7:0] u;
      logic [7:0] v;
      logic [2:0] alpha;
   } layer_result_t;

   // eight-level mix, alpha 7 is fully opaque
   function automatic logic [7:0] blend(input logic [7:0] base,
                                        input logic [7:0] ovl,
                                        input logic [2:0] alpha);
      logic [3:0]  inv;
      logic [10:0] acc;
      inv = 4'd8 - {1'b0, alpha};
      // weights sum to 8, so the sum never exceeds 11 bits
      acc = ({3'b000, base} * {7'b0000000, inv}) + ({3'b000, ovl} * {8'b00000000, alpha});
      if (alpha == 3'd0) begin
         return base;
      end else if (alpha == 3'd7) begin
         return ovl;
      end
      return acc[10:3];
   endfunction

endpackage

`default_nettype wire

// ==== pixel_position_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ovl_macros.svh"

module pixel_position_tracker (
   input  logic            clk,
   input  logic            resetb,
   input  logic            enable,
   input  logic            dvi,
   input  ovl_pkg::dtype_e dtypei,
   input  logic [7:0]      data0i,
   input  logic [7:0]      data1i,
   input  logic [7:0]      data2i,
   input  logic [15:0]     meta_datai,
   pix_stream_if.src       stream
);
   import ovl_pkg::*;

   logic [`OVL_DIM_WIDTH-1:0] row_pos;
   logic [`OVL_DIM_WIDTH-1:0] col_pos;

   // position counters and the position tagged onto each beat
   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         row_pos    <= '0;
         col_pos    <= '0;
         stream.dv  <= 1'b0;
         stream.row <= '0;
         stream.col <= '0;
      end else begin
         stream.dv  <= dvi;
         // a pixel carries the column before the increment
         stream.row <= enable ? row_pos : '0;
         stream.col <= enable ? col_pos : '0;
         if (!enable) begin
            row_pos <= '0;
            col_pos <= '0;
         end else if (dvi) begin
            case (dtypei)
               FRAME_START: begin
                  row_pos <= '0;
                  col_pos <= '0;
               end
               ROW_END: begin
                  row_pos <= row_pos + 1'b1;
                  col_pos <= '0;
               end
               PIXEL:   col_pos <= col_pos + 1'b1;
               default: ;
            endcase
         end
      end
   end

   // beat payload
   always_ff @(posedge clk) begin
      stream.dtype     <= dtypei;
      stream.data0     <= data0i;
      stream.data1     <= data1i;
      stream.data2     <= data2i;
      stream.meta_data <= meta_datai;
   end

   // rows wider than the counter would fold back onto column 0
   assert property (@(posedge clk) disable iff (!resetb)
      (enable && dvi && dtypei == PIXEL) |=> (col_pos != '0))
      else $error("column counter wrapped within a row");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the overlay testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_overlay -o tb_overlay_sim
if [ $? -ne 0 ]; then
   echo "compile step failed"
   exit 1
fi

./obj_dir/tb_overlay_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
   exit 1
fi
exit 0

// ==== tb.f ====
+incdir+.
ovl_pkg.sv
ovl_if.sv
pixel_position_tracker.sv
overlay_layer.sv
layer_compositor.sv
overlay_top.sv
tb_overlay.sv

// ==== tb_overlay.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ovl_macros.svh"

module tb_overlay;
   import ovl_pkg::*;

   localparam int COLS  = 12;
   localparam int ROWS  = 6;
   localparam int NL    = `OVL_NUM_LAYERS;
   localparam int LW    = $clog2(NL);
   localparam int DEPTH = `OVL_MEM_DEPTH;
   // a frame is FRAME_START, META, rows with ROW_END, FRAME_END, at most one idle per beat
   localparam int FRAME_MAX = 2 * (3 + ROWS * (COLS + 1));
   // window writes, memory writes and the flush before them
   localparam int SETUP_MAX = 4 + DEPTH + 4;
   localparam int STIM_MAX  = 10 * FRAME_MAX + 13 * SETUP_MAX + 7 * 12 + 16;
   localparam int LIMIT     = 2 * STIM_MAX;

   typedef struct packed {
      logic        dv;
      dtype_e      dtype;
      logic [7:0]  d0;
      logic [7:0]  d1;
      logic [7:0]  d2;
      logic [15:0] meta;
   } beat_t;

   logic           clk;
   logic           resetb;
   logic           enable;
   logic           dvi;
   dtype_e         dtypei;
   logic [7:0]     data0i;
   logic [7:0]     data1i;
   logic [7:0]     data2i;
   logic [15:0]    meta_datai;
   logic           cfg_we;
   logic [LW-1:0]  cfg_layer;
   logic [6:0]     cfg_addr;
   logic [31:0]    cfg_wdata;
   logic           dvo;
   dtype_e         dtypeo;
   logic [7:0]     data0o;
   logic [7:0]     data1o;
   logic [7:0]     data2o;
   logic [15:0]    meta_datao;

   // reference model state
   int             win [NL][4];
   logic [31:0]    words [NL][DEPTH];
   int             row_cnt = 0;
   int             col_cnt = 0;
   int             addr [NL];
   bit             hi_half [NL];

   beat_t          expq [$];
   logic [23:0]    seen [$];
   int             errors = 0;
   int             err_mark = 0;
   int             checks = 0;
   int             cycles = 0;

   overlay_top UUT (
      .clk        (clk),
      .resetb     (resetb),
      .enable     (enable),
      .dvi        (dvi),
      .dtypei     (dtypei),
      .data0i     (data0i),
      .data1i     (data1i),
      .data2i     (data2i),
      .meta_datai (meta_datai),
      .cfg_we     (cfg_we),
      .cfg_layer  (cfg_layer),
      .cfg_addr   (cfg_addr),
      .cfg_wdata  (cfg_wdata),
      .dvo        (dvo),
      .dtypeo     (dtypeo),
      .data0o     (data0o),
      .data1o     (data1o),
      .data2o     (data2o),
      .meta_datao (meta_datao)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // eight-level mix, weights add up to 8
   function automatic logic [7:0] mix(input logic [7:0] base, input logic [7:0] top,
                                      input logic [2:0] a);
      int sum;
      sum = int'(base) * (8 - int'(a)) + int'(top) * int'(a);
      if (a == 3'd0) return base;
      if (a == 3'd7) return top;
      return 8'(sum >> 3);
   endfunction

   // expected output for one input beat, advancing the model
   function automatic beat_t predict(input beat_t b);
      beat_t       e;
      int          r;
      int          c;
      logic [31:0] w;
      logic [15:0] h;
      e = b;
      r = row_cnt;
      c = col_cnt;
      if (!enable) begin
         row_cnt = 0;
         col_cnt = 0;
         for (int l = 0; l < NL; l++) begin
            addr[l] = 0;
            hi_half[l] = 1'b0;
         end
         return e;
      end
      if (b.dv && b.dtype == FRAME_START) begin
         row_cnt = 0;
         col_cnt = 0;
      end else if (b.dv && b.dtype == ROW_END) begin
         row_cnt = row_cnt + 1;
         col_cnt = 0;
      end else if (b.dv && b.dtype == PIXEL) begin
         col_cnt = col_cnt + 1;
      end
      for (int l = 0; l < NL; l++) begin
         if (b.dv && b.dtype == PIXEL && r >= win[l][1] && r < win[l][1] + win[l][2] &&
             c >= win[l][0] && c < win[l][0] + win[l][3]) begin
            w = words[l][addr[l]];
            h = hi_half[l] ? w[31:16] : w[15:0];
            // a zero half shows the layer below
            if (h != 16'h0000) begin
               e.d0 = mix(e.d0, {h[12:6], 1'b0}, h[15:13]);
               e.d1 = mix(e.d1, {w[5:0], 2'b00}, h[15:13]);
               e.d2 = mix(e.d2, {w[21:16], 2'b00}, h[15:13]);
            end
            if (hi_half[l]) addr[l] = (addr[l] + 1) % DEPTH;
            hi_half[l] = !hi_half[l];
         end
         if (b.dv && b.dtype == FRAME_END) begin
            addr[l] = 0;
            hi_half[l] = 1'b0;
         end
      end
      return e;
   endfunction

   function automatic beat_t make_beat(input logic v, input dtype_e t, input logic [7:0] y,
                                       input logic [7:0] u, input logic [7:0] vc);
      beat_t b;
      b.dv    = v;
      b.dtype = t;
      b.d0    = y;
      b.d1    = u;
      b.d2    = vc;
      b.meta  = 16'($urandom);
      return b;
   endfunction

   // overlay word contents, mode 0 opaque, 1 partial alphas with zero halves, 2 random
   function automatic logic [31:0] fill(input int l, input int a, input int mode);
      logic [31:0] w;
      logic [2:0]  alo;
      logic [2:0]  ahi;
      alo = 3'd7;
      ahi = 3'd7;
      if (mode == 1) begin
         alo = 3'((2 * a) % 6 + 1);
         ahi = 3'((2 * a + 1) % 6 + 1);
      end
      w = {ahi, 7'(a * 5 + l * 17), 6'(a * 3 + l * 9 + 1), alo, 7'(a * 11 + 3 + l), 6'(a ^ 42)};
      if (mode == 1 && a % 4 == 3) w[15:0] = 16'h0000;
      if (mode == 1 && a % 4 == 1) w[31:16] = 16'h0000;
      if (mode == 2) begin
         w = $urandom;
         if ($urandom % 5 == 0) w[15:0] = 16'h0000;
      end
      return w;
   endfunction

   // one clock of stimulus, the expected beat goes into the queue
   task automatic step(input beat_t b, input logic we, input int l, input int a,
                       input logic [31:0] d);
      @(posedge clk);
      #5;
      dvi        = b.dv;
      dtypei     = b.dtype;
      data0i     = b.d0;
      data1i     = b.d1;
      data2i     = b.d2;
      meta_datai = b.meta;
      cfg_we     = we;
      cfg_layer  = l[LW-1:0];
      cfg_addr   = 7'(a);
      cfg_wdata  = d;
      if (we && a >= 64) words[l][a - 64] = d;
      if (we && a < 4) win[l][a] = int'(d[`OVL_DIM_WIDTH-1:0]);
      expq.push_back(predict(b));
   endtask

   task automatic idle(input int n);
      for (int i = 0; i < n; i++) begin
         step(make_beat(1'b0, META, 8'($urandom), 8'($urandom), 8'($urandom)), 1'b0, 0, 0, 0);
      end
   endtask

   // random gaps between stream beats
   task automatic send(input beat_t b);
      if ($urandom % 4 == 0) idle(1);
      step(b, 1'b0, 0, 0, 0);
   endtask

   task automatic setup_layer(input int l, input int cs, input int rs, input int nr,
                              input int nc, input int mode);
      idle(4);
      step(make_beat(1'b0, META, 0, 0, 0), 1'b1, l, 0, 32'(cs));
      step(make_beat(1'b0, META, 0, 0, 0), 1'b1, l, 1, 32'(rs));
      step(make_beat(1'b0, META, 0, 0, 0), 1'b1, l, 2, 32'(nr));
      step(make_beat(1'b0, META, 0, 0, 0), 1'b1, l, 3, 32'(nc));
      for (int a = 0; a < DEPTH; a++) begin
         step(make_beat(1'b0, META, 0, 0, 0), 1'b1, l, 64 + a, fill(l, a, mode));
      end
   endtask

   task automatic send_frame(input bit rnd);
      logic [7:0] y;
      logic [7:0] u;
      logic [7:0] v;
      send(make_beat(1'b1, FRAME_START, 0, 0, 0));
      send(make_beat(1'b1, META, 8'h5a, 8'ha5, 8'h3c));
      for (int r = 0; r < ROWS; r++) begin
         for (int c = 0; c < COLS; c++) begin
            y = rnd ? 8'($urandom) : 8'(16 + r * 29 + c * 7);
            u = rnd ? 8'($urandom) : 8'(128 + r * 5 - c * 3);
            v = rnd ? 8'($urandom) : 8'(64 + c * 13 + r);
            send(make_beat(1'b1, PIXEL, y, u, v));
         end
         send(make_beat(1'b1, ROW_END, 0, 0, 0));
      end
      send(make_beat(1'b1, FRAME_END, 0, 0, 0));
   endtask

   task automatic end_test(input int num, input string name);
      idle(6);
      $display("test %0d %s: %0d errors", num, name, errors - err_mark);
      err_mark = errors;
   endtask

   // output lags the queued beat by three cycles
   always @(negedge clk) begin : compare
      beat_t e;
      if (expq.size() == 4) begin
         e = expq.pop_front();
         checks++;
         assert (dvo == e.dv) else begin
            $display("Fail %0t: dvo is %0b, expected %0b", $time, dvo, e.dv);
            errors++;
         end
         if (e.dv) begin
            assert (dtypeo == e.dtype && meta_datao == e.meta) else begin
               $display("Fail %0t: type/meta %0h/%h, expected %0h/%h", $time,
                        dtypeo, meta_datao, e.dtype, e.meta);
               errors++;
            end
            assert ({data0o, data1o, data2o} == {e.d0, e.d1, e.d2}) else begin
               $display("Fail %0t: yuv %h %h %h, expected %h %h %h", $time,
                        data0o, data1o, data2o, e.d0, e.d1, e.d2);
               errors++;
            end
            if (dtypeo == PIXEL) seen.push_back({data0o, data1o, data2o});
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > LIMIT) begin
         $display("timeout: the run went past %0d cycles", LIMIT);
         $display("Done: errors found");
         $finish;
      end
   end

   initial begin : main
      int dummy;
      bit same;
      dummy      = $urandom(32'h17fa);
      resetb     = 1'b0;
      enable     = 1'b0;
      dvi        = 1'b0;
      dtypei     = META;
      data0i     = 8'h00;
      data1i     = 8'h00;
      data2i     = 8'h00;
      meta_datai = 16'h0000;
      cfg_we     = 1'b0;
      cfg_layer  = '0;
      cfg_addr   = 7'd0;
      cfg_wdata  = 32'h0;
      for (int l = 0; l < NL; l++) begin
         addr[l] = 0;
         hi_half[l] = 1'b0;
         for (int i = 0; i < 4; i++) win[l][i] = 0;
      end
      repeat (4) @(posedge clk);
      #5;
      resetb = 1'b1;

      idle(4);
      send_frame(1'b1);
      end_test(1, "enable low pass-through");

      enable = 1'b1;
      setup_layer(0, 2, 1, 3, 5, 0);
      setup_layer(1, 0, 0, 0, 0, 0);
      send_frame(1'b0);
      end_test(2, "opaque window");

      setup_layer(0, 0, 0, ROWS, COLS, 1);
      send_frame(1'b0);
      end_test(3, "partial alphas");

      setup_layer(0, 1, 1, 4, 8, 1);
      setup_layer(1, 5, 2, 4, 6, 1);
      send_frame(1'b0);
      end_test(4, "overlapping layers");

      seen.delete();
      send_frame(1'b0);
      send_frame(1'b0);
      idle(6);
      same = (seen.size() == 2 * ROWS * COLS);
      for (int i = 0; same && i < ROWS * COLS; i++) begin
         same = (seen[i] == seen[i + ROWS * COLS]);
      end
      assert (same) else begin
         $display("Fail %0t: second frame output differs from the first", $time);
         errors++;
      end
      end_test(5, "frame restart");

      for (int f = 0; f < 4; f++) begin
         setup_layer(0, $urandom % COLS, $urandom % ROWS, 1 + $urandom % ROWS,
                     1 + $urandom % COLS, 2);
         setup_layer(1, $urandom % COLS, $urandom % ROWS, 1 + $urandom % ROWS,
                     1 + $urandom % COLS, 2);
         send_frame(1'b1);
      end
      end_test(6, "random frames");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire
